// File: filelist.f
src/div_cfg_pkg.sv
src/div_types_pkg.sv
src/div_fifo.sv
src/div_lane.sv
src/div_dispatch.sv
src/div_collect.sv
src/div_array_top.sv
verif/div_array_tb.sv

// File: src/div_array_top.sv
`timescale 1ns/1ps
`default_nettype none

module div_array_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    req_valid,
	output logic                    req_ready,
	input  div_types_pkg::div_req_t req,
	output logic                    rsp_valid,
	input  logic                    rsp_ready,
	output div_types_pkg::div_rsp_t rsp
);
	import div_cfg_pkg::*;
	import div_types_pkg::*;

	logic                    q_req_valid;
	logic                    q_req_ready;
	div_req_t                q_req;

	logic [num_lanes-1:0]    lane_start_valid;
	logic [num_lanes-1:0]    lane_idle;
	div_req_t                lane_req;
	logic [num_lanes-1:0]    res_valid;
	logic [num_lanes-1:0]    res_ready;
	div_rsp_t [num_lanes-1:0] res;

	logic                    col_valid;
	logic                    col_ready;
	div_rsp_t                col_rsp;

	// ------------------------------------------------------------------------
	// Request side
	// ------------------------------------------------------------------------
	div_fifo #(.payload_t(div_req_t)) req_fifo_i (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (req_valid),
		.in_ready  (req_ready),
		.in_data   (req),
		.out_valid (q_req_valid),
		.out_ready (q_req_ready),
		.out_data  (q_req)
	);

	div_dispatch div_dispatch_i (
		.clk              (clk),
		.reset            (reset),
		.in_valid         (q_req_valid),
		.in_ready         (q_req_ready),
		.in_req           (q_req),
		.lane_start_valid (lane_start_valid),
		.lane_idle        (lane_idle),
		.lane_req         (lane_req)
	);

	for (genvar i = 0; i < num_lanes; i++) begin : g_lane
		div_lane div_lane_i (
			.clk         (clk),
			.reset       (reset),
			.start_valid (lane_start_valid[i]),
			.idle        (lane_idle[i]),
			.start_req   (lane_req),
			.res_valid   (res_valid[i]),
			.res_ready   (res_ready[i]),
			.res         (res[i])
		);
	end

	// ------------------------------------------------------------------------
	// Response side
	// ------------------------------------------------------------------------
	div_collect div_collect_i (
		.clk       (clk),
		.reset     (reset),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.res       (res),
		.out_valid (col_valid),
		.out_ready (col_ready),
		.out_rsp   (col_rsp)
	);

	div_fifo #(.payload_t(div_rsp_t)) rsp_fifo_i (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (col_valid),
		.in_ready  (col_ready),
		.in_data   (col_rsp),
		.out_valid (rsp_valid),
		.out_ready (rsp_ready),
		.out_data  (rsp)
	);

endmodule

`default_nettype wire

// File: src/div_cfg_pkg.sv
`default_nettype none

// ---------------------------------------------------------------------------
// Sizing of the divide array
// ---------------------------------------------------------------------------
package div_cfg_pkg;

	// Operand and tag widths
	localparam int data_width = 32;
	localparam int tag_width = 4;

	// Parallel radix-2 lanes and queue depth on each side
	localparam int num_lanes = 4;
	localparam int fifo_depth = 4;

	// One quotient bit per iteration
	localparam int cycles_per_div = data_width;

	// Derived widths
	localparam int lane_idx_width = (num_lanes > 1) ? $clog2(num_lanes) : 1;
	localparam int iter_cnt_width = $clog2(cycles_per_div);
	localparam int fifo_ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int fifo_cnt_width = $clog2(fifo_depth + 1);

endpackage

`default_nettype wire

// File: src/div_collect.sv
`timescale 1ns/1ps
`default_nettype none

module div_collect (
	input  logic                                                  clk,
	input  logic                                                  reset,
	input  logic [div_cfg_pkg::num_lanes-1:0]                     res_valid,
	output logic [div_cfg_pkg::num_lanes-1:0]                     res_ready,
	input  div_types_pkg::div_rsp_t [div_cfg_pkg::num_lanes-1:0]  res,
	output logic                                                  out_valid,
	input  logic                                                  out_ready,
	output div_types_pkg::div_rsp_t                               out_rsp
);
	import div_types_pkg::*;

	// Follows the dispatcher order, which keeps responses in request order
	lane_idx_t ptr;
	logic      fire;

	assign out_valid = res_valid[ptr];
	assign out_rsp = res[ptr];
	assign fire = out_valid && out_ready;

	// Downstream ready goes back to the selected lane only
	always_comb begin
		res_ready = '0;
		res_ready[ptr] = out_ready;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ptr <= '0;
		end else if (fire) begin
			ptr <= next_lane(ptr);
		end
	end

endmodule

`default_nettype wire

// File: src/div_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module div_dispatch (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                in_valid,
	output logic                                in_ready,
	input  div_types_pkg::div_req_t             in_req,
	output logic [div_cfg_pkg::num_lanes-1:0]   lane_start_valid,
	input  logic [div_cfg_pkg::num_lanes-1:0]   lane_idle,
	output div_types_pkg::div_req_t             lane_req
);
	import div_types_pkg::*;

	// Lane that receives the next request
	lane_idx_t ptr;
	logic      fire;

	// Only the pointed-to lane may start; a busy lane stalls the queue
	assign in_ready = lane_idle[ptr];
	assign fire = in_valid && in_ready;

	// Request bus is shared, the start strobe picks the lane
	assign lane_req = in_req;

	always_comb begin
		lane_start_valid = '0;
		lane_start_valid[ptr] = in_valid;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ptr <= '0;
		end else if (fire) begin
			ptr <= next_lane(ptr);
		end
	end

endmodule

`default_nettype wire

// File: src/div_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module div_fifo #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);
	import div_cfg_pkg::*;

	payload_t                  mem [fifo_depth];
	logic [fifo_ptr_width-1:0] wr_ptr;
	logic [fifo_ptr_width-1:0] rd_ptr;
	logic [fifo_cnt_width-1:0] count;
	logic                      push;
	logic                      pop;

	function automatic logic [fifo_ptr_width-1:0] ptr_inc(
		input logic [fifo_ptr_width-1:0] ptr
	);
		logic [fifo_ptr_width-1:0] nxt;
		if (ptr == fifo_ptr_width'(fifo_depth - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	// Handshake from the occupancy alone, so push and pop can overlap
	assign in_ready = (count != fifo_cnt_width'(fifo_depth));
	assign out_valid = (count != '0);
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;
	assign out_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/div_lane.sv
`timescale 1ns/1ps
`default_nettype none

// Iterative restoring divider, one quotient bit per cycle.
//  7 /  3 =  2 r  1     -7 /  3 = -2 r -1
//  7 / -3 = -2 r  1     -7 / -3 =  2 r -1
module div_lane (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    start_valid,
	output logic                    idle,
	input  div_types_pkg::div_req_t start_req,
	output logic                    res_valid,
	input  logic                    res_ready,
	output div_types_pkg::div_rsp_t res
);
	import div_cfg_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_sign,
		st_done
	} state_t;

	state_t                    state;
	logic [iter_cnt_width-1:0] iter_cnt;

	logic [data_width-1:0]     rem;
	logic [data_width-1:0]     quo;
	logic [data_width-1:0]     divisor;
	logic                      quo_neg;
	logic                      rem_neg;
	logic [tag_width-1:0]      tag_r;

	logic                      start;
	logic [data_width:0]       rem_shift;
	logic [data_width+1:0]     trial;
	logic                      borrow;

	function automatic logic [data_width-1:0] negate(input logic [data_width-1:0] v);
		return ~v + 1'b1;
	endfunction

	function automatic logic [data_width-1:0] magnitude(input logic [data_width-1:0] v);
		return v[data_width-1] ? negate(v) : v;
	endfunction

	assign start = start_valid && idle;

	// ------------------------------------------------------------------------
	// One restoring step
	// ------------------------------------------------------------------------
	// The shifted remainder keeps its carry bit so divisors above half range
	// still divide correctly
	assign rem_shift = {rem, quo[data_width-1]};
	assign trial = {1'b0, rem_shift} - {2'b00, divisor};
	assign borrow = trial[data_width+1];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			iter_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_run;
						iter_cnt <= '0;
					end
				end
				st_run: begin
					iter_cnt <= iter_cnt + 1'b1;
					if (iter_cnt == iter_cnt_width'(cycles_per_div - 1)) begin
						state <= st_sign;
					end
				end
				st_sign: state <= st_done;
				default: begin
					// Hold until the collector takes the result
					if (res_ready) begin
						state <= st_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			st_idle: begin
				if (start) begin
					rem <= '0;
					quo <= start_req.is_signed ? magnitude(start_req.dividend)
						: start_req.dividend;
					divisor <= start_req.is_signed ? magnitude(start_req.divisor)
						: start_req.divisor;
					quo_neg <= start_req.is_signed
						&& (start_req.dividend[data_width-1] ^ start_req.divisor[data_width-1]);
					rem_neg <= start_req.is_signed && start_req.dividend[data_width-1];
					tag_r <= start_req.tag;
				end
			end
			st_run: begin
				rem <= borrow ? rem_shift[data_width-1:0] : trial[data_width-1:0];
				quo <= {quo[data_width-2:0], ~borrow};
			end
			st_sign: begin
				if (quo_neg) begin
					quo <= negate(quo);
				end
				if (rem_neg) begin
					rem <= negate(rem);
				end
			end
			default: ;
		endcase
	end

	assign idle = (state == st_idle);
	assign res_valid = (state == st_done);
	assign res = '{quotient: quo, remainder: rem, tag: tag_r};

endmodule

`default_nettype wire

// File: src/div_types_pkg.sv
`default_nettype none

// ---------------------------------------------------------------------------
// Request, response and lane numbering types
// ---------------------------------------------------------------------------
package div_types_pkg;
	import div_cfg_pkg::*;

	typedef logic [lane_idx_width-1:0] lane_idx_t;

	// 69 bits with the default sizing
	typedef struct packed {
		logic [data_width-1:0] dividend;
		logic [data_width-1:0] divisor;
		logic                  is_signed;
		logic [tag_width-1:0]  tag;
	} div_req_t;

	// 68 bits with the default sizing
	typedef struct packed {
		logic [data_width-1:0] quotient;
		logic [data_width-1:0] remainder;
		logic [tag_width-1:0]  tag;
	} div_rsp_t;

	// Round-robin successor, shared by dispatcher and collector so both
	// walk the lanes in the same order
	function automatic lane_idx_t next_lane(input lane_idx_t idx);
		lane_idx_t nxt;
		if (idx == lane_idx_t'(num_lanes - 1)) begin
			nxt = '0;
		end else begin
			nxt = idx + 1'b1;
		end
		return nxt;
	endfunction

endpackage

`default_nettype wire

// File: verif/div_array_tb.sv
`timescale 1ns/1ps
`default_nettype none

module div_array_tb;
	import div_cfg_pkg::*;
	import div_types_pkg::*;

	localparam int num_directed = 16;
	localparam int num_random = 16;
	localparam int num_tests = num_directed + num_random;
	localparam int stall_cycles = 120;
	localparam int latency_cycles = cycles_per_div + 3;
	localparam int timeout_cycles = num_tests * latency_cycles + stall_cycles + 100;

	typedef struct packed {
		logic [data_width-1:0] dividend;
		logic [data_width-1:0] divisor;
		logic                  is_signed;
		logic [data_width-1:0] exp_q;
		logic [data_width-1:0] exp_r;
	} test_vec_t;

	logic      clk;
	logic      reset;
	logic      req_valid;
	logic      req_ready;
	div_req_t  req;
	logic      rsp_valid;
	logic      rsp_ready;
	div_rsp_t  rsp;

	test_vec_t   tests [num_tests];
	logic [31:0] lcg_state;
	logic        saw_full;
	int          cycle_cnt = 0;
	int          err_cnt = 0;
	int          rsp_cnt = 0;

	div_array_top div_array_top_i (
		.clk       (clk),
		.reset     (reset),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp)
	);

	always #2 clk = ~clk;

	// ------------------------------------------------------------------------
	// Stimulus table and reference model
	// ------------------------------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic test_vec_t make_vec(input logic [data_width-1:0] dd,
		input logic [data_width-1:0] dv, input logic s,
		input logic [data_width-1:0] q, input logic [data_width-1:0] r);
		return '{dividend: dd, divisor: dv, is_signed: s, exp_q: q, exp_r: r};
	endfunction

	// Zero divisor gives an all-ones quotient magnitude and the dividend
	// magnitude as remainder, then the usual signs
	function automatic test_vec_t model_vec(input logic [data_width-1:0] dd,
		input logic [data_width-1:0] dv, input logic s);
		logic [data_width-1:0] q;
		logic [data_width-1:0] r;
		if (dv == '0) begin
			q = (s && dd[data_width-1]) ? data_width'(1) : '1;
			r = dd;
		end else if (s) begin
			if (dd == {1'b1, {(data_width-1){1'b0}}} && dv == '1) begin
				// Most negative by minus one wraps
				q = dd;
				r = '0;
			end else begin
				q = $signed(dd) / $signed(dv);
				r = $signed(dd) % $signed(dv);
			end
		end else begin
			q = dd / dv;
			r = dd % dv;
		end
		return make_vec(dd, dv, s, q, r);
	endfunction

	task automatic build_table();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		// Unsigned
		tests[0] = make_vec(32'd100, 32'd7, 1'b0, 32'd14, 32'd2);
		tests[1] = make_vec(32'd5, 32'd9, 1'b0, 32'd0, 32'd5);
		tests[2] = make_vec(32'hffffffff, 32'd3, 1'b0, 32'h55555555, 32'd0);
		tests[3] = make_vec(32'hffffffff, 32'd10, 1'b0, 32'h19999999, 32'd5);
		tests[4] = make_vec(32'h80000000, 32'hc0000000, 1'b0, 32'd0, 32'h80000000);
		tests[5] = make_vec(32'hffffffff, 32'hfffffffe, 1'b0, 32'd1, 32'd1);
		// Signed, all four sign combinations
		tests[6] = make_vec(32'd7, 32'd3, 1'b1, 32'd2, 32'd1);
		tests[7] = make_vec(32'hfffffff9, 32'd3, 1'b1, 32'hfffffffe, 32'hffffffff);
		tests[8] = make_vec(32'd7, 32'hfffffffd, 1'b1, 32'hfffffffe, 32'd1);
		tests[9] = make_vec(32'hfffffff9, 32'hfffffffd, 1'b1, 32'd2, 32'hffffffff);
		tests[10] = make_vec(32'hffffff9c, 32'd7, 1'b1, 32'hfffffff2, 32'hfffffffe);
		tests[11] = make_vec(32'h80000000, 32'hffffffff, 1'b1, 32'h80000000, 32'd0);
		// Divide by zero
		tests[12] = make_vec(32'h000004d2, 32'd0, 1'b0, 32'hffffffff, 32'h000004d2);
		tests[13] = make_vec(32'd0, 32'd0, 1'b0, 32'hffffffff, 32'd0);
		tests[14] = make_vec(32'd7, 32'd0, 1'b1, 32'hffffffff, 32'd7);
		tests[15] = make_vec(32'hfffffff9, 32'd0, 1'b1, 32'd1, 32'hfffffff9);
		for (int i = num_directed; i < num_tests; i++) begin
			lcg_state = lcg_next(lcg_state);
			a = lcg_state;
			lcg_state = lcg_next(lcg_state);
			b = lcg_state;
			lcg_state = lcg_next(lcg_state);
			c = lcg_state;
			// Shifted divisor spreads the quotient sizes
			tests[i] = model_vec(a, b >> c[4:0], c[31]);
		end
	endtask

	// ------------------------------------------------------------------------
	// Request and response sides
	// ------------------------------------------------------------------------
	task automatic send_request(input int idx);
		logic accepted;
		req = '{dividend: tests[idx].dividend, divisor: tests[idx].divisor,
			is_signed: tests[idx].is_signed, tag: tag_width'(idx)};
		req_valid = 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			accepted = req_ready;
			@(posedge clk);
			#0.5;
		end
		req_valid = 1'b0;
	endtask

	task automatic check_response(input int idx, input div_rsp_t got);
		int errs_before;
		errs_before = err_cnt;
		assert (got.tag == tag_width'(idx)) else begin
			$display("CHECK FAILED at %0t: test %0d tag %0d, expected %0d",
				$time, idx, got.tag, idx % (1 << tag_width));
			err_cnt++;
		end
		assert (got.quotient == tests[idx].exp_q) else begin
			$display("CHECK FAILED at %0t: test %0d quotient %h, expected %h",
				$time, idx, got.quotient, tests[idx].exp_q);
			err_cnt++;
		end
		assert (got.remainder == tests[idx].exp_r) else begin
			$display("CHECK FAILED at %0t: test %0d remainder %h, expected %h",
				$time, idx, got.remainder, tests[idx].exp_r);
			err_cnt++;
		end
		$display("test %0d %0s: %h / %h gives q %h r %h, %0s", idx,
			tests[idx].is_signed ? "signed" : "unsigned", tests[idx].dividend,
			tests[idx].divisor, got.quotient, got.remainder,
			(err_cnt == errs_before) ? "ok" : "mismatch");
	endtask

	// Response is checked here and transfers on the next edge
	task automatic take_response();
		logic taken;
		taken = 1'b0;
		while (!taken) begin
			if (rsp_valid && rsp_ready) begin
				check_response(rsp_cnt, rsp);
				rsp_cnt++;
				taken = 1'b1;
			end
			@(posedge clk);
			#0.5;
		end
	endtask

	task automatic measure_latency();
		int n;
		send_request(0);
		n = 0;
		while (!rsp_valid && n < 2 * latency_cycles) begin
			@(posedge clk);
			#0.5;
			n++;
		end
		assert (n == latency_cycles) else begin
			$display("CHECK FAILED at %0t: latency %0d cycles, expected %0d",
				$time, n, latency_cycles);
			err_cnt++;
		end
		$display("latency test: %0d cycles", n);
	endtask

	// Hard stop on a hung pipeline
	initial begin
		while (cycle_cnt < timeout_cycles) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout after %0d cycles with %0d of %0d responses received",
			cycle_cnt, rsp_cnt, num_tests);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		rsp_ready = 1'b1;
		saw_full = 1'b0;
		lcg_state = 32'h0120ec5c;
		build_table();
		repeat (10) @(posedge clk);
		#0.5;
		reset = 1'b0;

		fork
			begin
				measure_latency();
				for (int i = 1; i < num_tests; i++) begin
					send_request(i);
				end
			end
			begin
				take_response();
				// Stall the output while the burst piles up
				rsp_ready = 1'b0;
				repeat (stall_cycles) begin
					@(posedge clk);
					#0.5;
					if (!req_ready) begin
						saw_full = 1'b1;
					end
				end
				rsp_ready = 1'b1;
				while (rsp_cnt < num_tests) begin
					take_response();
				end
			end
		join

		assert (saw_full) else begin
			$display("req_ready never fell while responses were stalled");
			err_cnt++;
		end
		$display("back-pressure test: req_ready low seen %0d", saw_full);
		repeat (20) begin
			@(posedge clk);
			#0.5;
			assert (!rsp_valid) else begin
				$display("Unexpected extra response after all %0d were received", num_tests);
				err_cnt++;
			end
		end

		$display("Tests run %0d, errors %0d", num_tests + 2, err_cnt);
		if (err_cnt == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
